// File: hw/routing_pkg.sv
package routing_pkg;

    // output ports of a 2D mesh router
    // EAST steps x up, WEST steps x down
    // NORTH steps y down, SOUTH steps y up
    typedef enum logic [2:0] {
        LOCAL = 3'd0,  // eject to the attached endpoint
        EAST  = 3'd1,  // x + 1
        NORTH = 3'd2,  // y - 1
        WEST  = 3'd3,  // x - 1
        SOUTH = 3'd4   // y + 1
    } port_e;

    localparam int NUM_PORTS = 5;  // legal codes are 0 .. NUM_PORTS-1

endpackage

// File: hw/mesh_addr_decode.sv
module mesh_addr_decode #(
    parameter int NX = 4,  // routers along x
    parameter int NY = 4   // routers along y
) (
    input  logic [((NX > 1) ? $clog2(NX) : 1) + ((NY > 1) ? $clog2(NY) : 1) - 1:0] addr,
    output logic [((NX > 1) ? $clog2(NX) : 1) - 1:0]                               x,
    output logic [((NY > 1) ? $clog2(NY) : 1) - 1:0]                               y,
    output logic                                                                   valid
);

    localparam int XW = (NX > 1) ? $clog2(NX) : 1;
    localparam int YW = (NY > 1) ? $clog2(NY) : 1;
    localparam int AW = XW + YW;

    logic x_ok;
    logic y_ok;

    // x in the low bits, y above it
    assign x = addr[XW-1:0];
    assign y = addr[AW-1:XW];

    // a field can hold codes past the mesh edge when NX or NY is not a power of two
    assign x_ok = int'(x) < NX;
    assign y_ok = int'(y) < NY;

    assign valid = x_ok & y_ok;

endmodule

// File: hw/xy_route.sv
module xy_route
    import routing_pkg::*;
#(
    parameter int NX = 4,  // routers along x
    parameter int NY = 4   // routers along y
) (
    input  logic [((NX > 1) ? $clog2(NX) : 1) - 1:0] cur_x,
    input  logic [((NY > 1) ? $clog2(NY) : 1) - 1:0] cur_y,
    input  logic [((NX > 1) ? $clog2(NX) : 1) - 1:0] dest_x,
    input  logic [((NY > 1) ? $clog2(NY) : 1) - 1:0] dest_y,
    output port_e                                    port
);

    localparam int XW = (NX > 1) ? $clog2(NX) : 1;
    localparam int YW = (NY > 1) ? $clog2(NY) : 1;

    logic [XW-1:0] dx_cur;
    logic [XW-1:0] dx_dest;
    logic [YW-1:0] dy_cur;
    logic [YW-1:0] dy_dest;
    logic          x_gt;
    logic          x_lt;
    logic          y_gt;
    logic          y_lt;

    assign dx_cur  = cur_x;
    assign dx_dest = dest_x;
    assign dy_cur  = cur_y;
    assign dy_dest = dest_y;

    assign x_gt = dx_dest > dx_cur;
    assign x_lt = dx_dest < dx_cur;
    assign y_gt = dy_dest > dy_cur;  // south is y + 1
    assign y_lt = dy_dest < dy_cur;

    // dimension order, x resolved first so no turn from y back to x
    always_comb begin
        if (x_gt) begin
            port = EAST;
        end else if (x_lt) begin
            port = WEST;
        end else if (y_gt) begin
            port = SOUTH;
        end else if (y_lt) begin
            port = NORTH;
        end else begin
            port = LOCAL;  // arrived
        end
    end

endmodule

// File: hw/next_hop.sv
module next_hop
    import routing_pkg::*;
#(
    parameter int NX = 4,  // routers along x
    parameter int NY = 4   // routers along y
) (
    input  logic [((NX > 1) ? $clog2(NX) : 1) - 1:0] cur_x,
    input  logic [((NY > 1) ? $clog2(NY) : 1) - 1:0] cur_y,
    input  port_e                                    port,
    output logic [((NX > 1) ? $clog2(NX) : 1) - 1:0] next_x,
    output logic [((NY > 1) ? $clog2(NY) : 1) - 1:0] next_y
);

    localparam int XW = (NX > 1) ? $clog2(NX) : 1;
    localparam int YW = (NY > 1) ? $clog2(NY) : 1;

    logic at_east_edge;
    logic at_west_edge;
    logic at_north_edge;
    logic at_south_edge;

    // mesh borders, no wraparound links
    assign at_east_edge  = int'(cur_x) >= NX - 1;
    assign at_west_edge  = cur_x == '0;
    assign at_north_edge = cur_y == '0;
    assign at_south_edge = int'(cur_y) >= NY - 1;

    // the neighbour address follows from our own, no neighbour bus needed
    always_comb begin
        next_x = cur_x;
        next_y = cur_y;
        case (port)
            EAST: begin
                if (!at_east_edge) begin
                    next_x = cur_x + XW'(1);
                end
            end
            WEST: begin
                if (!at_west_edge) begin
                    next_x = cur_x - XW'(1);
                end
            end
            NORTH: begin
                if (!at_north_edge) begin
                    next_y = cur_y - YW'(1);
                end
            end
            SOUTH: begin
                if (!at_south_edge) begin
                    next_y = cur_y + YW'(1);
                end
            end
            default: begin
                // LOCAL stays on this router
                next_x = cur_x;
                next_y = cur_y;
            end
        endcase
    end

endmodule

// File: hw/look_ahead_route.sv
module look_ahead_route
    import routing_pkg::*;
#(
    parameter int NX = 4,  // routers along x
    parameter int NY = 4   // routers along y
) (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic                                     in_valid,
    input  logic [((NX > 1) ? $clog2(NX) : 1) - 1:0] cur_x,
    input  logic [((NY > 1) ? $clog2(NY) : 1) - 1:0] cur_y,
    input  logic [((NX > 1) ? $clog2(NX) : 1) - 1:0] dest_x,
    input  logic [((NY > 1) ? $clog2(NY) : 1) - 1:0] dest_y,
    input  logic                                     cur_ok,
    input  logic                                     dest_ok,
    input  port_e                                    cur_port,
    output logic                                     out_valid,
    output port_e                                    destport,
    output port_e                                    lkdestport,
    output logic                                     addr_error
);

    localparam int XW = (NX > 1) ? $clog2(NX) : 1;
    localparam int YW = (NY > 1) ? $clog2(NY) : 1;

    logic          req_error;
    logic          port_legal;
    port_e         req_port;

    logic          s1_valid;
    port_e         s1_port;
    logic [XW-1:0] s1_cur_x;
    logic [YW-1:0] s1_cur_y;
    logic [XW-1:0] s1_dest_x;
    logic [YW-1:0] s1_dest_y;
    logic          s1_error;

    logic [XW-1:0] hop_x;
    logic [YW-1:0] hop_y;
    port_e         hop_port;

    assign req_error  = ~(cur_ok & dest_ok);          // either address off the mesh
    assign port_legal = int'(cur_port) < NUM_PORTS;
    assign req_port   = (req_error || !port_legal) ? LOCAL : cur_port;

    // stage 1 control
    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= in_valid;
        end
    end

    // stage 1 payload
    always_ff @(posedge clk) begin
        if (in_valid) begin
            s1_port   <= req_port;
            s1_cur_x  <= cur_x;
            s1_cur_y  <= cur_y;
            s1_dest_x <= dest_x;
            s1_dest_y <= dest_y;
            s1_error  <= req_error;
        end
    end

    // router reached through the current port
    next_hop #(
        .NX(NX),
        .NY(NY)
    ) hop (
        .cur_x (s1_cur_x),
        .cur_y (s1_cur_y),
        .port  (s1_port),
        .next_x(hop_x),
        .next_y(hop_y)
    );

    // port that router will take
    xy_route #(
        .NX(NX),
        .NY(NY)
    ) hop_route (
        .cur_x (hop_x),
        .cur_y (hop_y),
        .dest_x(s1_dest_x),
        .dest_y(s1_dest_y),
        .port  (hop_port)
    );

    // stage 2, result registers
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid  <= 1'b0;
            destport   <= LOCAL;
            lkdestport <= LOCAL;
            addr_error <= 1'b0;
        end else begin
            out_valid <= s1_valid;
            if (s1_valid) begin
                destport   <= s1_port;
                lkdestport <= s1_error ? LOCAL : hop_port;  // bad coords give no route
                addr_error <= s1_error;
            end
        end
    end

endmodule

// File: hw/route_unit.sv
module route_unit
    import routing_pkg::*;
#(
    parameter int NX = 4,  // routers along x
    parameter int NY = 4   // routers along y
) (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic                                     in_valid,        // one request per strobe
    input  logic [((NX > 1) ? $clog2(NX) : 1) +
                  ((NY > 1) ? $clog2(NY) : 1) - 1:0] current_r_addr,
    input  logic [((NX > 1) ? $clog2(NX) : 1) +
                  ((NY > 1) ? $clog2(NY) : 1) - 1:0] dest_e_addr,
    output logic                                     out_valid,
    output port_e                                    destport,        // port at this router
    output port_e                                    lkdestport,      // port at the next router
    output logic                                     addr_error
);

    localparam int XW = (NX > 1) ? $clog2(NX) : 1;
    localparam int YW = (NY > 1) ? $clog2(NY) : 1;

    logic [XW-1:0] cur_x;
    logic [YW-1:0] cur_y;
    logic          cur_ok;
    logic [XW-1:0] dest_x;
    logic [YW-1:0] dest_y;
    logic          dest_ok;
    port_e         cur_port;

    mesh_addr_decode #(
        .NX(NX),
        .NY(NY)
    ) router_decode (
        .addr (current_r_addr),
        .x    (cur_x),
        .y    (cur_y),
        .valid(cur_ok)
    );

    // one endpoint per router, same layout as a router address
    mesh_addr_decode #(
        .NX(NX),
        .NY(NY)
    ) dest_decode (
        .addr (dest_e_addr),
        .x    (dest_x),
        .y    (dest_y),
        .valid(dest_ok)
    );

    xy_route #(
        .NX(NX),
        .NY(NY)
    ) current_route (
        .cur_x (cur_x),
        .cur_y (cur_y),
        .dest_x(dest_x),
        .dest_y(dest_y),
        .port  (cur_port)
    );

    look_ahead_route #(
        .NX(NX),
        .NY(NY)
    ) look_ahead (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .cur_x     (cur_x),
        .cur_y     (cur_y),
        .dest_x    (dest_x),
        .dest_y    (dest_y),
        .cur_ok    (cur_ok),
        .dest_ok   (dest_ok),
        .cur_port  (cur_port),
        .out_valid (out_valid),
        .destport  (destport),
        .lkdestport(lkdestport),
        .addr_error(addr_error)
    );

endmodule

// File: verif/route_checker.sv
module route_checker
    import routing_pkg::*;
#(
    parameter int NX = 4,  // routers along x
    parameter int NY = 4   // routers along y
) (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic                                     in_valid,
    input  logic [((NX > 1) ? $clog2(NX) : 1) +
                  ((NY > 1) ? $clog2(NY) : 1) - 1:0] current_r_addr,
    input  logic [((NX > 1) ? $clog2(NX) : 1) +
                  ((NY > 1) ? $clog2(NY) : 1) - 1:0] dest_e_addr,
    input  logic                                     out_valid,
    input  port_e                                    destport,
    input  port_e                                    lkdestport,
    input  logic                                     addr_error,
    input  logic                                     finish_req,
    output int                                       error_total,
    output logic                                     report_done
);

    localparam int XW = (NX > 1) ? $clog2(NX) : 1;
    localparam int YW = (NY > 1) ? $clog2(NY) : 1;

    int cycle           = 0;
    int value_errors    = 0;
    int protocol_errors = 0;
    int coverage_errors = 0;
    int seen_output     = 0;
    int request_count   = 0;
    int pulse_count     = 0;
    int port_count[NUM_PORTS];

    int due_q[$];    // cycle the result must show up
    int dest_q[$];
    int lk_q[$];
    int err_q[$];
    int cur_q[$];    // addresses kept for messages
    int dst_q[$];

    assign error_total = value_errors + protocol_errors + coverage_errors;

    initial begin
        report_done = 1'b0;
        foreach (port_count[i]) begin
            port_count[i] = 0;
        end
    end

    // dimension-ordered rule with x resolved first
    function automatic int expected_port(input int cx, input int cy, input int dx, input int dy);
        if (dx > cx) return int'(EAST);
        if (dx < cx) return int'(WEST);
        if (dy > cy) return int'(SOUTH);
        if (dy < cy) return int'(NORTH);
        return int'(LOCAL);
    endfunction

    task automatic record_request();
        int cx;
        int cy;
        int dx;
        int dy;
        int nx;
        int ny;
        int bad;
        int exp_dest;
        int exp_lk;
        cx  = int'(current_r_addr) % (1 << XW);
        cy  = int'(current_r_addr) >> XW;
        dx  = int'(dest_e_addr) % (1 << XW);
        dy  = int'(dest_e_addr) >> XW;
        bad = (cx >= NX || cy >= NY || dx >= NX || dy >= NY) ? 1 : 0;
        if (bad != 0) begin
            exp_dest = int'(LOCAL);
            exp_lk   = int'(LOCAL);
        end else begin
            exp_dest = expected_port(cx, cy, dx, dy);
            nx       = cx;
            ny       = cy;
            case (exp_dest)
                int'(EAST):  nx = cx + 1;
                int'(WEST):  nx = cx - 1;
                int'(NORTH): ny = cy - 1;
                int'(SOUTH): ny = cy + 1;
                default:     nx = cx;  // stays put
            endcase
            exp_lk = expected_port(nx, ny, dx, dy);
            port_count[exp_dest]++;
        end
        request_count++;
        due_q.push_back(cycle + 2);
        dest_q.push_back(exp_dest);
        lk_q.push_back(exp_lk);
        err_q.push_back(bad);
        cur_q.push_back(int'(current_r_addr));
        dst_q.push_back(int'(dest_e_addr));
    endtask

    task automatic compare_result();
        if (destport !== port_e'(dest_q[0])) begin
            value_errors++;
            $display("Error at time %0t: destport %0d, expected %0d (cur %h dest %h)",
                     $time, destport, dest_q[0], cur_q[0], dst_q[0]);
        end
        if (lkdestport !== port_e'(lk_q[0])) begin
            value_errors++;
            $display("Error at time %0t: lkdestport %0d, expected %0d (cur %h dest %h)",
                     $time, lkdestport, lk_q[0], cur_q[0], dst_q[0]);
        end
        if (addr_error !== (err_q[0] != 0)) begin
            value_errors++;
            $display("Error at time %0t: addr_error %0d, expected %0d (cur %h dest %h)",
                     $time, addr_error, err_q[0], cur_q[0], dst_q[0]);
        end
    endtask

    task automatic check_outputs();
        if (out_valid === 1'b1) begin
            pulse_count++;
        end
        if (due_q.size() > 0 && due_q[0] == cycle) begin
            if (out_valid !== 1'b1) begin
                protocol_errors++;
                $display("out_valid missing at time %0t for request cur %h dest %h",
                         $time, cur_q[0], dst_q[0]);
            end else begin
                compare_result();
            end
            seen_output = 1;
            void'(due_q.pop_front());
            void'(dest_q.pop_front());
            void'(lk_q.pop_front());
            void'(err_q.pop_front());
            void'(cur_q.pop_front());
            void'(dst_q.pop_front());
        end else if (out_valid !== 1'b0) begin
            protocol_errors++;
            if (due_q.size() == 0) begin
                $display("out_valid pulse at time %0t with no request outstanding", $time);
            end else begin
                $display("out_valid pulse at time %0t before the result was due", $time);
            end
        end else if (seen_output == 0) begin
            // reset values hold until the first result
            if (destport !== LOCAL || lkdestport !== LOCAL || addr_error !== 1'b0) begin
                value_errors++;
                $display("Error at time %0t: outputs left their reset values while idle", $time);
            end
        end
    endtask

    task automatic final_checks();
        if (pulse_count < request_count) begin
            protocol_errors++;
            $display("%0d requests were never answered", request_count - pulse_count);
        end
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (port_count[p] == 0) begin
                coverage_errors++;
                $display("no in-range request was routed to port code %0d", p);
            end
        end
        $display("error counts: value %0d, protocol %0d, coverage %0d",
                 value_errors, protocol_errors, coverage_errors);
    endtask

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (finish_req) begin
            if (!report_done) begin
                final_checks();
                report_done <= 1'b1;
            end
        end else if (!reset) begin
            check_outputs();  // a new request is never due in its own cycle
            if (in_valid) begin
                record_request();
            end
        end
    end

endmodule

// File: verif/tb_route_unit.sv
module tb_route_unit
    import routing_pkg::*;
();

    localparam int NX              = 5;  // not powers of two, so off-mesh codes exist
    localparam int NY              = 3;
    localparam int XW              = (NX > 1) ? $clog2(NX) : 1;
    localparam int YW              = (NY > 1) ? $clog2(NY) : 1;
    localparam int AW              = XW + YW;
    localparam int CLK_PERIOD      = 4;
    localparam int RESET_CYCLES    = 16;
    localparam int STIM_CYCLES     = 2000;
    localparam int DRAIN_CYCLES    = 6;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + STIM_CYCLES + 50;
    localparam int unsigned SEED   = 32'h339f;

    logic          clk;
    logic          reset;
    logic          in_valid;
    logic [AW-1:0] current_r_addr;
    logic [AW-1:0] dest_e_addr;
    logic          out_valid;
    port_e         destport;
    port_e         lkdestport;
    logic          addr_error;
    logic          finish_req;
    logic          report_done;
    int            error_total;

    route_unit #(
        .NX(NX),
        .NY(NY)
    ) dut0 (
        .clk           (clk),
        .reset         (reset),
        .in_valid      (in_valid),
        .current_r_addr(current_r_addr),
        .dest_e_addr   (dest_e_addr),
        .out_valid     (out_valid),
        .destport      (destport),
        .lkdestport    (lkdestport),
        .addr_error    (addr_error)
    );

    route_checker #(
        .NX(NX),
        .NY(NY)
    ) checker0 (
        .clk           (clk),
        .reset         (reset),
        .in_valid      (in_valid),
        .current_r_addr(current_r_addr),
        .dest_e_addr   (dest_e_addr),
        .out_valid     (out_valid),
        .destport      (destport),
        .lkdestport    (lkdestport),
        .addr_error    (addr_error),
        .finish_req    (finish_req),
        .error_total   (error_total),
        .report_done   (report_done)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // about one address in ten lands off the mesh
    function automatic logic [AW-1:0] random_addr();
        logic [XW-1:0] x;
        logic [YW-1:0] y;
        int unsigned   pick;
        pick = $urandom % 100;
        if (pick < 5) begin
            x = XW'(NX + ($urandom % ((1 << XW) - NX)));  // x past the east edge
            y = YW'($urandom % (1 << YW));
        end else if (pick < 10) begin
            x = XW'($urandom % (1 << XW));
            y = YW'(NY + ($urandom % ((1 << YW) - NY)));  // y past the south edge
        end else begin
            x = XW'($urandom % NX);
            y = YW'($urandom % NY);
        end
        return {y, x};
    endfunction

    initial begin
        int unsigned   seed_init;
        logic [AW-1:0] cur_addr;
        logic [AW-1:0] dest_addr;
        seed_init      = $urandom(SEED);
        clk            = 1'b0;
        reset          = 1'b1;
        in_valid       = 1'b0;
        current_r_addr = '0;
        dest_e_addr    = '0;
        finish_req     = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < STIM_CYCLES; i++) begin
            @(posedge clk);
            cur_addr  = random_addr();
            dest_addr = random_addr();
            if (($urandom % 100) < 5) begin
                dest_addr = cur_addr;  // extra LOCAL routes
            end
            in_valid       <= ($urandom % 100) < 70;
            current_r_addr <= cur_addr;
            dest_e_addr    <= dest_addr;
        end
        @(posedge clk);
        in_valid <= 1'b0;
        repeat (DRAIN_CYCLES) @(posedge clk);  // let the pipeline empty
        finish_req <= 1'b1;
        wait (report_done);
        if (error_total == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: the run did not reach its end at time %0t", $time);
        $display("tests failed");
        $finish;
    end

endmodule

// File: verilog.f
hw/routing_pkg.sv
hw/mesh_addr_decode.sv
hw/xy_route.sv
hw/next_hop.sv
hw/look_ahead_route.sv
hw/route_unit.sv
verif/route_checker.sv
verif/tb_route_unit.sv
